// File: design/noc_defs.svh
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

//////////////////////////////////////////////////////////////////////////////
// link geometry
//////////////////////////////////////////////////////////////////////////////

// virtual channels on the link, also the arbiter width
`define NOC_VCS 4

// flit payload bits
`define NOC_DATA_W 32

// slots in each vc buffer
// both credit counters start from this value
`define NOC_VC_DEPTH 4

// wide enough to hold NOC_VC_DEPTH itself, not just depth-1
`define NOC_CNT_W 3

`endif

// File: design/noc_flit_pkg.sv
`default_nettype none

`include "noc_defs.svh"

package noc_flit_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // flit format
  ////////////////////////////////////////////////////////////////////////////

  // virtual channel number
  typedef logic [$clog2(`NOC_VCS)-1:0] vc_t;

  // flit payload
  typedef logic [`NOC_DATA_W-1:0] data_t;

  // one flit as it travels on the link
  // valid marks a flit on the wire in this cycle
  // last marks the tail flit of a packet
  // vc selects the buffer the flit belongs to
  typedef struct packed {
    logic  valid;
    logic  last;
    vc_t   vc;
    data_t data;
  } flit_t;

  // single-flit packets carry last on their only flit
  // a head flit with last low locks the output until its tail

endpackage

`default_nettype wire

// File: design/noc_link_pkg.sv
`default_nettype none

`include "noc_defs.svh"

package noc_link_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // credit flow control
  ////////////////////////////////////////////////////////////////////////////

  // one pulse bit per vc
  // a high bit for one cycle hands back exactly one slot
  // used both towards the sender and from the receiver
  typedef logic [`NOC_VCS-1:0] credit_t;

  // credits held for one vc
  // counts from NOC_VC_DEPTH down to zero
  typedef logic [`NOC_CNT_W-1:0] credit_cnt_t;

  // zero means the vc must not send
  // the receiver has no free slot left for it

  // counters never rise above NOC_VC_DEPTH
  // a higher value means a credit was returned twice

endpackage

`default_nettype wire

// File: design/noc_arbiter_rr.sv
`timescale 1ns/1ps
`default_nettype none

// round-robin arbiter, purely combinational
// the caller keeps the grant in a register and feeds it back as gnt
module noc_arbiter_rr #(
  parameter int n = 2
) (
  input  logic [n-1:0] req,
  input  logic         en,
  input  logic [n-1:0] gnt,
  output logic [n-1:0] nxt_gnt
);

  // mask[k] has a bit set for every requester served before k
  // the current holder sits last in line, so it never blocks others
  logic [n-1:0] mask [n];

  //////////////////////////////////////////////////////////////////////////
  // precedence masks
  //////////////////////////////////////////////////////////////////////////

  always_comb begin : build_mask
    logic run;
    int   p;
    for (int k = 0; k < n; k++) begin
      mask[k] = '0;
      run     = 1'b1;
      // walk backwards from k until the grant holder is reached
      for (int d = 1; d < n; d++) begin
        p          = (k - d + n) % n;
        run        = run & ~gnt[p];
        mask[k][p] = run;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // next grant
  //////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < n; k++) begin : gen_nxt
    // k wins if it requests and nobody ahead of it does
    // with no request at all the old grant stays
    // en low freezes the grant, e.g. while a packet owns the link
    assign nxt_gnt[k] = en ? ((req[k] & ~|(mask[k] & req)) | (~|req & gnt[k]))
                           : gnt[k];
  end

  // a one-hot grant must stay one-hot, otherwise two vcs pop at once
  always_comb begin
    if ($onehot(gnt)) begin
      assert final ($onehot(nxt_gnt))
        else $error("arbiter lost one-hot grant: gnt=%b nxt_gnt=%b", gnt, nxt_gnt);
    end
  end

endmodule

`default_nettype wire

// File: design/noc_vc_demux.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module noc_vc_demux (
  input  logic                  clk,
  input  logic                  reset,
  input  noc_flit_pkg::flit_t   in_flit,
  output noc_flit_pkg::flit_t   wr_flit,
  output logic [`NOC_VCS-1:0]   wr_en
);

  // input register, one flit per cycle
  noc_flit_pkg::flit_t flit_q;

  always_ff @(posedge clk) begin
    flit_q <= in_flit;
    // only the valid bit needs clearing
    if (reset) begin
      flit_q.valid <= 1'b0;
    end
  end

  // same flit goes to every buffer
  assign wr_flit = flit_q;

  // one-hot write enable from the vc field
  always_comb begin
    wr_en = '0;
    if (flit_q.valid) begin
      wr_en[flit_q.vc] = 1'b1;
    end
  end

  // sender must only use existing vcs
  // an out-of-range vc would be dropped without a buffer
  vc_in_range: assert property (
    @(posedge clk) disable iff (reset)
    in_flit.valid |-> (int'(in_flit.vc) < `NOC_VCS)
  ) else $error("flit on vc %0d, only %0d vcs", in_flit.vc, `NOC_VCS);

endmodule

`default_nettype wire

// File: design/noc_vc_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

// circular fifo holding the flits of one vc
module noc_vc_buffer (
  input  logic                clk,
  input  logic                reset,
  input  logic                wr_en,
  input  noc_flit_pkg::flit_t wr_flit,
  input  logic                pop,
  output noc_flit_pkg::flit_t head,
  output logic                empty
);

  localparam int ptr_w = (`NOC_VC_DEPTH > 1) ? $clog2(`NOC_VC_DEPTH) : 1;
  localparam logic [ptr_w-1:0] last_slot = ptr_w'(`NOC_VC_DEPTH - 1);
  localparam logic [`NOC_CNT_W-1:0] depth_c = `NOC_VC_DEPTH;

  noc_flit_pkg::flit_t mem [`NOC_VC_DEPTH];

  logic [ptr_w-1:0]      wr_ptr;
  logic [ptr_w-1:0]      rd_ptr;
  logic [`NOC_CNT_W-1:0] count;
  logic                  full;

  //////////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_flit;
    end
  end

  // head is read straight from the array
  // a flit written at one edge is here right after it
  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == depth_c);

  //////////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      // write and pop together leave the count alone
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a write into a full buffer means the sender spent a credit it never had
  no_overflow: assert property (
    @(posedge clk) disable iff (reset) wr_en |-> !full
  ) else $error("vc buffer overflow, upstream credit violation");

  // output stage must only pop a vc it saw as non-empty
  no_underflow: assert property (
    @(posedge clk) disable iff (reset) pop |-> !empty
  ) else $error("vc buffer popped while empty");

endmodule

`default_nettype wire

// File: design/noc_vc_output.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module noc_vc_output (
  input  logic                  clk,
  input  logic                  reset,
  input  noc_flit_pkg::flit_t   head [`NOC_VCS],
  input  logic [`NOC_VCS-1:0]   empty,
  input  noc_link_pkg::credit_t down_credit,
  output noc_flit_pkg::flit_t   out_flit,
  output noc_link_pkg::credit_t up_credit,
  output logic [`NOC_VCS-1:0]   pop
);

  localparam noc_link_pkg::credit_cnt_t full_credits = `NOC_VC_DEPTH;

  // downstream credits per vc
  noc_link_pkg::credit_cnt_t cnt [`NOC_VCS];

  logic [`NOC_VCS-1:0] req;
  logic [`NOC_VCS-1:0] gnt;
  logic [`NOC_VCS-1:0] nxt_gnt;
  logic                locked;
  noc_flit_pkg::flit_t sel_flit;

  //////////////////////////////////////////////////////////////////////////
  // per-vc credit counters
  //////////////////////////////////////////////////////////////////////////

  for (genvar v = 0; v < `NOC_VCS; v++) begin : gen_vc
    // a vc asks only with a flit waiting and room downstream
    assign req[v] = ~empty[v] & (cnt[v] != '0);

    always_ff @(posedge clk) begin
      if (reset) begin
        cnt[v] <= full_credits;
      end else begin
        cnt[v] <= cnt[v] + noc_link_pkg::credit_cnt_t'(down_credit[v])
                         - noc_link_pkg::credit_cnt_t'(pop[v]);
      end
    end

    // more credits than slots means the receiver returned one twice
    cnt_bounded: assert property (
      @(posedge clk) disable iff (reset) cnt[v] <= full_credits
    ) else $error("vc %0d credit counter above depth", v);
  end

  //////////////////////////////////////////////////////////////////////////
  // arbitration with packet lock
  //////////////////////////////////////////////////////////////////////////

  // while a packet is open the grant is frozen on its vc
  noc_arbiter_rr #(
    .n (`NOC_VCS)
  ) arbiter_inst (
    .req     (req),
    .en      (~locked),
    .gnt     (gnt),
    .nxt_gnt (nxt_gnt)
  );

  // pop uses the fresh grant so a head flit leaves in its first cycle
  assign pop = nxt_gnt & req;

  // head of the popped vc, zero when nothing is popped
  always_comb begin
    sel_flit = '0;
    for (int v = 0; v < `NOC_VCS; v++) begin
      if (pop[v]) begin
        sel_flit = head[v];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      // grant on the top vc so vc 0 wins first
      gnt    <= {1'b1, {(`NOC_VCS-1){1'b0}}};
      locked <= 1'b0;
    end else begin
      gnt <= nxt_gnt;
      // non-last opens a packet, last closes it
      if (|pop) begin
        locked <= ~sel_flit.last;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // output register and credit return
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    out_flit       <= sel_flit;
    out_flit.valid <= |pop;
    // each pop frees one slot, handed back next cycle
    up_credit      <= pop;
    if (reset) begin
      out_flit.valid <= 1'b0;
      up_credit      <= '0;
    end
  end

endmodule

`default_nettype wire

// File: design/noc_vc_link.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

// one vc link stage: demux, per-vc buffers, arbitrated output
module noc_vc_link (
  input  logic                  clk,
  input  logic                  reset,
  input  noc_flit_pkg::flit_t   in_flit,
  output noc_link_pkg::credit_t up_credit,
  output noc_flit_pkg::flit_t   out_flit,
  input  noc_link_pkg::credit_t down_credit
);

  // demux to buffers
  noc_flit_pkg::flit_t wr_flit;
  logic [`NOC_VCS-1:0] wr_en;

  // buffers to output stage
  noc_flit_pkg::flit_t head [`NOC_VCS];
  logic [`NOC_VCS-1:0] empty;
  logic [`NOC_VCS-1:0] pop;

  noc_vc_demux demux_inst (
    .clk     (clk),
    .reset   (reset),
    .in_flit (in_flit),
    .wr_flit (wr_flit),
    .wr_en   (wr_en)
  );

  // one fifo per vc, all share the write data
  for (genvar v = 0; v < `NOC_VCS; v++) begin : gen_buf
    noc_vc_buffer buffer_inst (
      .clk     (clk),
      .reset   (reset),
      .wr_en   (wr_en[v]),
      .wr_flit (wr_flit),
      .pop     (pop[v]),
      .head    (head[v]),
      .empty   (empty[v])
    );
  end

  noc_vc_output output_inst (
    .clk         (clk),
    .reset       (reset),
    .head        (head),
    .empty       (empty),
    .down_credit (down_credit),
    .out_flit    (out_flit),
    .up_credit   (up_credit),
    .pop         (pop)
  );

endmodule

`default_nettype wire

// File: testbench/tb_noc_vc_link.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module tb_noc_vc_link;

  localparam int vcs       = `NOC_VCS;
  localparam int depth     = `NOC_VC_DEPTH;
  localparam int rand_pkts = 80;
  localparam int sat_pkts  = 6;
  // test phases
  localparam int ph_rand   = 0;
  localparam int ph_sat    = 1;
  localparam int ph_drain  = 2;
  // sink behavior: hold every slot, free at random, free at once
  localparam int sink_hold = 0;
  localparam int sink_rand = 1;
  localparam int sink_fast = 2;

  logic                  clk = 1'b0;
  logic                  reset = 1'b1;
  noc_flit_pkg::flit_t   in_flit = '0;
  noc_link_pkg::credit_t up_credit;
  noc_flit_pkg::flit_t   out_flit;
  noc_link_pkg::credit_t down_credit = '0;

  logic [31:0] lfsr = 32'h2cf7_9b32;
  int          phase = ph_rand;
  int          sink_mode = sink_hold;

  // source side: credits, flits still to send, current packet length
  int credits [vcs];
  int src_left [vcs];
  int cur_left [vcs];
  int pend_len [vcs][$];
  // flits seen at the output whose upstream credit is still due
  int uncredited [vcs];
  // sink side free slots
  int sink_free [vcs];
  // reference model, one queue per vc
  noc_flit_pkg::flit_t exp_q [vcs][$];

  int gen_budget = rand_pkts;
  int gen_flits = 0;
  bit sat_loaded = 1'b0;
  bit open_pkt;
  int open_vc;
  bit have_prev;
  int prev_vc;
  bit check_first;
  // status flags for the sequencer
  bit idle = 1'b0;
  bit stalled = 1'b0;
  bit sent_all = 1'b0;

  always #2 clk = ~clk;

  noc_vc_link noc_vc_link_inst (
    .clk         (clk),
    .reset       (reset),
    .in_flit     (in_flit),
    .up_credit   (up_credit),
    .out_flit    (out_flit),
    .down_credit (down_credit)
  );

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "test stopped at first error");
  endtask

  // galois lfsr, one step per bit taken
  function automatic int unsigned take_bits(input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = (r << 1) | {31'b0, lfsr[0]};
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // source, sink and reference model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : model
    noc_flit_pkg::flit_t   f;
    noc_link_pkg::credit_t dc;
    int                    v;
    int                    s;
    int                    want;
    bit                    found;
    bit                    all_left;
    bit                    flag;
    if (reset) begin
      for (s = 0; s < vcs; s++) begin
        credits[s]    = depth;
        sink_free[s]  = depth;
        uncredited[s] = 0;
        cur_left[s]   = 0;
      end
      open_pkt    = 1'b0;
      have_prev   = 1'b0;
      check_first = 1'b1;
      in_flit     <= '0;
      down_credit <= '0;
      idle        <= 1'b0;
    end else begin
      // output monitor
      if (out_flit.valid) begin
        v = int'(out_flit.vc);
        assert (exp_q[v].size() > 0)
          else report_error($sformatf("output flit on vc %0d that was never sent", v));
        f = exp_q[v].pop_front();
        assert ({f.last, f.data} == {out_flit.last, out_flit.data})
          else report_error($sformatf("mismatch order_content vc %0d: expected %h actual %h",
                                      v, {f.last, f.data}, {out_flit.last, out_flit.data}));
        if (open_pkt) begin
          // body or tail must stay on the packet's vc
          assert (v == open_vc)
            else report_error($sformatf("mismatch no_interleave: expected %0d actual %0d",
                                        open_vc, v));
        end else begin
          // packet head
          all_left = 1'b1;
          for (s = 0; s < vcs; s++) begin
            if (src_left[s] == 0) all_left = 1'b0;
          end
          // every vc busy, so the next head comes from the next vc in turn
          if (sink_mode == sink_fast && have_prev && all_left) begin
            want = (prev_vc + 1) % vcs;
            assert (v == want)
              else report_error($sformatf("mismatch round_robin: expected %0d actual %0d",
                                          want, v));
          end
          if (check_first && phase == ph_sat) begin
            assert (v == 0)
              else report_error($sformatf("mismatch first_after_reset: expected 0 actual %0d",
                                          v));
          end
          check_first = 1'b0;
          prev_vc     = v;
          have_prev   = 1'b1;
        end
        open_pkt = !out_flit.last;
        open_vc  = v;
        assert (sink_free[v] > 0)
          else report_error($sformatf("flit arrived on vc %0d with no free downstream slot", v));
        sink_free[v]--;
        uncredited[v]++;
      end

      // credits coming back upstream
      // a credit with no flit out would let the sender overrun its buffer
      for (s = 0; s < vcs; s++) begin
        if (up_credit[s]) begin
          assert (uncredited[s] > 0)
            else report_error($sformatf("credit returned on vc %0d with no flit owed", s));
          uncredited[s]--;
          credits[s]++;
        end
      end

      // sink frees occupied slots
      dc = '0;
      for (s = 0; s < vcs; s++) begin
        if (sink_free[s] < depth) begin
          if (sink_mode == sink_fast || (sink_mode == sink_rand && take_bits(1) == 1)) begin
            dc[s] = 1'b1;
            sink_free[s]++;
          end
        end
      end
      down_credit <= dc;

      // packet generation
      if (phase == ph_rand && gen_budget > 0 && take_bits(2) == 0) begin
        v = int'(take_bits(2));
        s = int'(take_bits(2)) + 1;
        pend_len[v].push_back(s);
        src_left[v] += s;
        gen_flits   += s;
        gen_budget--;
      end
      if (phase == ph_sat && !sat_loaded) begin
        for (v = 0; v < vcs; v++) begin
          for (int k = 0; k < sat_pkts; k++) begin
            s = int'(take_bits(2)) + 1;
            pend_len[v].push_back(s);
            src_left[v] += s;
            gen_flits   += s;
          end
        end
        sat_loaded = 1'b1;
      end

      // send at most one flit, random start vc outside saturation
      found = 1'b0;
      f     = '0;
      want  = (phase == ph_rand) ? int'(take_bits(2)) : 0;
      if (phase != ph_rand || take_bits(2) != 0) begin
        for (int k = 0; k < vcs; k++) begin
          v = (want + k) % vcs;
          if (!found && credits[v] > 0 && src_left[v] > 0) begin
            if (cur_left[v] == 0) begin
              cur_left[v] = pend_len[v].pop_front();
            end
            f.valid = 1'b1;
            f.last  = (cur_left[v] == 1);
            f.vc    = noc_flit_pkg::vc_t'(v);
            f.data  = take_bits(32);
            exp_q[v].push_back(f);
            cur_left[v]--;
            src_left[v]--;
            credits[v]--;
            found = 1'b1;
          end
        end
      end
      in_flit <= f;

      // status for the sequencer
      flag = (phase != ph_rand || gen_budget == 0);
      for (s = 0; s < vcs; s++) begin
        if (src_left[s] != 0 || exp_q[s].size() != 0 || credits[s] != depth ||
            sink_free[s] != depth || uncredited[s] != 0) begin
          flag = 1'b0;
        end
      end
      idle <= flag;
      flag = sat_loaded;
      for (s = 0; s < vcs; s++) begin
        if (credits[s] != 0) flag = 1'b0;
      end
      stalled <= flag;
      flag = sat_loaded;
      for (s = 0; s < vcs; s++) begin
        if (src_left[s] != 0) flag = 1'b0;
      end
      sent_all <= flag;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////////////////////

  initial begin : run_test
    repeat (10) @(posedge clk);
    reset     <= 1'b0;
    sink_mode <= sink_rand;
    // random traffic until everything is back home
    @(posedge clk);
    while (!idle) @(posedge clk);
    // fresh reset, then load all vcs with the sink holding
    phase     <= ph_sat;
    sink_mode <= sink_hold;
    reset     <= 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    while (!stalled) @(posedge clk);
    repeat (20) @(posedge clk);
    sink_mode <= sink_fast;
    while (!sent_all) @(posedge clk);
    // drain at a random rate
    phase     <= ph_drain;
    sink_mode <= sink_rand;
    @(posedge clk);
    @(posedge clk);
    while (!idle) @(posedge clk);
    for (int v = 0; v < vcs; v++) begin
      assert (credits[v] == depth)
        else report_error($sformatf("mismatch final_credits vc %0d: expected %0d actual %0d",
                                    v, depth, credits[v]));
      assert (exp_q[v].size() == 0)
        else report_error($sformatf("mismatch completeness vc %0d: expected 0 actual %0d",
                                    v, exp_q[v].size()));
    end
    $display("STATUS: PASS");
    $finish;
  end

  // limit grows with every flit generated
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 40 * gen_flits + 2000) begin
      @(posedge clk);
      cycles++;
    end
    report_error($sformatf("timeout after %0d cycles with %0d flits generated",
                           cycles, gen_flits));
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/noc_flit_pkg.sv
design/noc_link_pkg.sv
design/noc_arbiter_rr.sv
design/noc_vc_demux.sv
design/noc_vc_buffer.sv
design/noc_vc_output.sv
design/noc_vc_link.sv
testbench/tb_noc_vc_link.sv

// File: Makefile
# Verilator build for the vc link stage

VERILATOR  ?= verilator
TOP        := tb_noc_vc_link
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the simulator exits non-zero on $$fatal, so make fails with it
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
